/* hw/serial_cfg_pkg.sv */
// Serial port configuration: frame layout and default sizing of the port.
`default_nettype none

package serial_cfg_pkg;

  // #########################################################################
  // Frame layout
  // #########################################################################

  localparam int DATA_BITS   = 8;   // Data bits in every frame.
  localparam int FRAME_SLOTS = 10;  // Start bit, data bits and the stop bit.

  // #########################################################################
  // Default sizing
  // #########################################################################

  // One bit period at the original system clock.
  localparam int DEFAULT_CLKS_PER_BIT = 869;
  localparam int DEFAULT_FIFO_DEPTH   = 16;  // Words held on each path.

  typedef logic [DATA_BITS-1:0] serial_byte_t;  // One byte on the line.

endpackage

`default_nettype wire

/* hw/serial_types_pkg.sv */
// Serial port host types: status levels and received words shared with the host.
`default_nettype none

package serial_types_pkg;

  import serial_cfg_pkg::*;

  // #########################################################################
  // Transmit side
  // #########################################################################

  typedef struct packed {
    logic full;   // Transmit FIFO full, the host must wait.
    logic empty;  // Nothing left to send.
  } tx_status_t;

  // #########################################################################
  // Receive side
  // #########################################################################

  // One decoded frame as it is stored in the receive FIFO.
  typedef struct packed {
    serial_byte_t data;       // Byte assembled MSB first.
    logic         frame_err;  // Stop bit was sampled low.
  } rx_word_t;

  typedef struct packed {
    logic full;   // Receive FIFO full, new frames are lost.
    logic empty;  // No word waiting for the host.
  } rx_status_t;

endpackage

`default_nettype wire

/* hw/lib_fifo.sv */
// Synchronous FIFO with a registered read port and full and empty levels.
`timescale 1ns/1ps
`default_nettype none

module lib_fifo
  import serial_cfg_pkg::*;
#(
  parameter int WIDTH      = DATA_BITS,
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
  input  logic             i_clk,
  input  logic             reset_n,
  input  logic             i_wr_en,
  input  logic [WIDTH-1:0] i_wr_data,
  input  logic             i_rd_en,
  output logic [WIDTH-1:0] o_rd_data,
  output logic             o_full,
  output logic             o_empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

  logic [WIDTH-1:0] l_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] l_wr_ptr;
  logic [PTR_W-1:0] l_rd_ptr;
  logic [CNT_W-1:0] l_count;
  logic             l_wr_ok;
  logic             l_rd_ok;

  assign o_full  = (l_count == CNT_FULL);
  assign o_empty = (l_count == '0);
  assign l_wr_ok = i_wr_en && !o_full;   // Writes into a full FIFO are lost.
  assign l_rd_ok = i_rd_en && !o_empty;  // Reads of an empty FIFO do nothing.

  always_ff @(posedge i_clk) begin
    if (l_wr_ok) begin
      l_mem[l_wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge i_clk or posedge reset_n) begin
    if (reset_n) begin
      l_wr_ptr  <= '0;
      l_rd_ptr  <= '0;
      l_count   <= '0;
      o_rd_data <= '0;
    end else begin
      if (l_wr_ok) begin
        l_wr_ptr <= (l_wr_ptr == PTR_LAST) ? '0 : l_wr_ptr + 1'b1;
      end
      if (l_rd_ok) begin
        o_rd_data <= l_mem[l_rd_ptr];  // Word stays visible until the next read.
        l_rd_ptr  <= (l_rd_ptr == PTR_LAST) ? '0 : l_rd_ptr + 1'b1;
      end
      // A read and a write in the same cycle leave the count unchanged.
      case ({l_wr_ok, l_rd_ok})
        2'b10:   l_count <= l_count + 1'b1;
        2'b01:   l_count <= l_count - 1'b1;
        default: l_count <= l_count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/nemu_serial_port_out.sv */
// Serial transmit path: byte FIFO feeding a bit-timed frame serializer, MSB first.
`timescale 1ns/1ps
`default_nettype none

module nemu_serial_port_out
  import serial_cfg_pkg::*, serial_types_pkg::*;
#(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT,
  parameter int FIFO_DEPTH   = DEFAULT_FIFO_DEPTH
) (
  input  logic         i_clk,
  input  logic         reset_n,
  input  logic         i_wr,
  input  serial_byte_t i_data,
  output tx_status_t   o_status,
  output logic         o_serial_tx
);

  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int SLOT_W    = $clog2(FRAME_SLOTS);
  localparam int IDX_W     = $clog2(DATA_BITS);
  localparam logic [BIT_CNT_W-1:0] BIT_END = BIT_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [SLOT_W-1:0] SLOT_IDLE  = '0;  // Also the stop bit.
  localparam logic [SLOT_W-1:0] SLOT_START = SLOT_W'(1);
  localparam logic [SLOT_W-1:0] SLOT_LAST  = SLOT_W'(FRAME_SLOTS - 1);

  logic                 l_running;    // A frame or its trailing idle is on the line.
  logic                 l_stop_done;  // Stop slot over, extra idle slot running.
  logic [SLOT_W-1:0]    l_slot;
  logic [BIT_CNT_W-1:0] l_bit_cnt;
  logic                 l_bit_end;
  logic                 l_pop;
  logic [IDX_W-1:0]     l_bit_idx;
  serial_byte_t         l_tx_byte;
  logic                 l_fifo_full;
  logic                 l_fifo_empty;

  assign l_bit_end = (l_bit_cnt == BIT_END);
  // The byte is fetched during the start bit, ready before the first data slot.
  assign l_pop     = l_running && (l_slot == SLOT_START) && (l_bit_cnt == '0);
  assign l_bit_idx = IDX_W'(SLOT_LAST - l_slot);  // Slot 2 carries bit 7.
  assign o_status  = '{full: l_fifo_full, empty: l_fifo_empty};

  lib_fifo #(
    .WIDTH      (DATA_BITS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .i_clk     (i_clk),
    .reset_n   (reset_n),
    .i_wr_en   (i_wr),
    .i_wr_data (i_data),
    .i_rd_en   (l_pop),
    .o_rd_data (l_tx_byte),
    .o_full    (l_fifo_full),
    .o_empty   (l_fifo_empty)
  );

  // #########################################################################
  // Slot sequencer
  // #########################################################################

  always_ff @(posedge i_clk or posedge reset_n) begin
    if (reset_n) begin
      l_running   <= 1'b0;
      l_stop_done <= 1'b0;
      l_slot      <= SLOT_IDLE;
      l_bit_cnt   <= '0;
    end else if (!l_running) begin
      if (!l_fifo_empty) begin
        l_running   <= 1'b1;  // Start bit begins at this edge.
        l_stop_done <= 1'b0;
        l_slot      <= SLOT_START;
        l_bit_cnt   <= '0;
      end
    end else if (!l_bit_end) begin
      l_bit_cnt <= l_bit_cnt + 1'b1;
    end else begin
      l_bit_cnt <= '0;
      if (l_slot == SLOT_LAST) begin
        l_slot <= SLOT_IDLE;  // Last data bit done, stop bit next.
      end else if (l_slot != SLOT_IDLE) begin
        l_slot <= l_slot + 1'b1;
      end else if (!l_stop_done) begin
        l_stop_done <= 1'b1;  // Hold the line high for one more period.
      end else begin
        l_running <= 1'b0;
      end
    end
  end

  // Line driver.
  always_comb begin
    if (l_slot == SLOT_IDLE) begin
      o_serial_tx = 1'b1;
    end else if (l_slot == SLOT_START) begin
      o_serial_tx = 1'b0;
    end else begin
      o_serial_tx = l_tx_byte[l_bit_idx];
    end
  end

endmodule

`default_nettype wire

/* hw/nemu_serial_port_in.sv */
// Serial receive path: start detection, mid-bit sampling, framing check and FIFO push.
`timescale 1ns/1ps
`default_nettype none

module nemu_serial_port_in
  import serial_cfg_pkg::*, serial_types_pkg::*;
#(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT,
  parameter int FIFO_DEPTH   = DEFAULT_FIFO_DEPTH
) (
  input  logic       i_clk,
  input  logic       reset_n,
  input  logic       i_serial_rx,
  input  logic       i_rd,
  output rx_word_t   o_word,
  output rx_status_t o_status
);

  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W     = $clog2(DATA_BITS);
  localparam logic [BIT_CNT_W-1:0] BIT_END  = BIT_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_END = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0]     IDX_LAST = IDX_W'(DATA_BITS - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t            l_state;
  logic [1:0]           l_sync;     // Two-flop synchronizer for the line.
  logic                 l_rx_prev;
  logic                 l_rx;
  logic                 l_fall;
  logic [BIT_CNT_W-1:0] l_bit_cnt;
  logic [IDX_W-1:0]     l_bit_idx;  // Data bits taken so far in this frame.
  serial_byte_t         l_shift;
  logic                 l_push;
  rx_word_t             l_push_word;
  logic                 l_fifo_full;
  logic                 l_fifo_empty;

  assign l_rx        = l_sync[1];
  assign l_fall      = l_rx_prev && !l_rx;
  assign l_push      = (l_state == RX_STOP) && (l_bit_cnt == BIT_END);
  assign l_push_word = '{data: l_shift, frame_err: !l_rx};  // Stop must read high.
  assign o_status    = '{full: l_fifo_full, empty: l_fifo_empty};

  lib_fifo #(
    .WIDTH      ($bits(rx_word_t)),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .i_clk     (i_clk),
    .reset_n   (reset_n),
    .i_wr_en   (l_push),  // Dropped by the FIFO when it is full.
    .i_wr_data (l_push_word),
    .i_rd_en   (i_rd),
    .o_rd_data (o_word),
    .o_full    (l_fifo_full),
    .o_empty   (l_fifo_empty)
  );

  // The line idles high, so the synchronizer resets to ones.
  always_ff @(posedge i_clk or posedge reset_n) begin
    if (reset_n) begin
      l_sync    <= 2'b11;
      l_rx_prev <= 1'b1;
    end else begin
      l_sync    <= {l_sync[0], i_serial_rx};
      l_rx_prev <= l_rx;
    end
  end

  // #########################################################################
  // Frame decoder
  // #########################################################################

  always_ff @(posedge i_clk or posedge reset_n) begin
    if (reset_n) begin
      l_state   <= RX_IDLE;
      l_bit_cnt <= '0;
      l_bit_idx <= '0;
    end else begin
      case (l_state)
        RX_IDLE: begin
          if (l_fall) begin
            l_state   <= RX_START;
            l_bit_cnt <= '0;
          end
        end
        RX_START: begin
          if (l_bit_cnt == HALF_END) begin
            l_bit_cnt <= '0;  // From here on every count ends mid-bit.
            l_bit_idx <= '0;
            l_state   <= l_rx ? RX_IDLE : RX_DATA;  // A high line was a glitch.
          end else begin
            l_bit_cnt <= l_bit_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (l_bit_cnt == BIT_END) begin
            l_bit_cnt <= '0;
            l_bit_idx <= l_bit_idx + 1'b1;
            if (l_bit_idx == IDX_LAST) begin
              l_state <= RX_STOP;
            end
          end else begin
            l_bit_cnt <= l_bit_cnt + 1'b1;
          end
        end
        default: begin
          // Stop bit. The word is pushed at its middle.
          if (l_bit_cnt == BIT_END) begin
            l_bit_cnt <= '0;
            l_state   <= RX_IDLE;
          end else begin
            l_bit_cnt <= l_bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits arrive MSB first and shift in from the bottom.
  always_ff @(posedge i_clk) begin
    if ((l_state == RX_DATA) && (l_bit_cnt == BIT_END)) begin
      l_shift <= {l_shift[DATA_BITS-2:0], l_rx};
    end
  end

endmodule

`default_nettype wire

/* hw/nemu_serial_port.sv */
// NEMU serial port top: transmit and receive paths sharing one bit timing.
`timescale 1ns/1ps
`default_nettype none

module nemu_serial_port
  import serial_cfg_pkg::*, serial_types_pkg::*;
#(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT,
  parameter int FIFO_DEPTH   = DEFAULT_FIFO_DEPTH
) (
  input  logic         i_clk,
  input  logic         reset_n,
  // Host transmit side.
  input  logic         i_tx_wr,
  input  serial_byte_t i_tx_data,
  output tx_status_t   o_tx_status,
  // Serial line.
  output logic         o_serial_tx,
  input  logic         i_serial_rx,
  // Host receive side.
  input  logic         i_rx_rd,
  output rx_word_t     o_rx_word,
  output rx_status_t   o_rx_status
);

  nemu_serial_port_out #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) u_port_out (
    .i_clk       (i_clk),
    .reset_n     (reset_n),
    .i_wr        (i_tx_wr),
    .i_data      (i_tx_data),
    .o_status    (o_tx_status),
    .o_serial_tx (o_serial_tx)
  );

  nemu_serial_port_in #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) u_port_in (
    .i_clk       (i_clk),
    .reset_n     (reset_n),
    .i_serial_rx (i_serial_rx),
    .i_rd        (i_rx_rd),
    .o_word      (o_rx_word),
    .o_status    (o_rx_status)
  );

endmodule

`default_nettype wire

/* test/nemu_serial_port_asserts.sv */
// Transmit path checks on the idle line level, FIFO pops and FIFO levels.
`timescale 1ns/1ps
`default_nettype none

module nemu_serial_port_asserts (
  input logic i_clk,
  input logic reset_n,
  input logic i_running,
  input logic i_pop,
  input logic i_fifo_full,
  input logic i_fifo_empty,
  input logic i_serial_tx
);

  // An idle transmitter with nothing queued holds the line high.
  idle_line_high: assert property (@(posedge i_clk) disable iff (reset_n)
    (!i_running && i_fifo_empty) |-> i_serial_tx)
    else $error("Transmit line low while the transmitter is idle");

  no_pop_when_empty: assert property (@(posedge i_clk) disable iff (reset_n)
    i_pop |-> !i_fifo_empty)
    else $error("Transmit FIFO read while empty");

  // The full level only drops when the serializer takes a byte.
  full_left_by_pop: assert property (@(posedge i_clk) disable iff (reset_n)
    $fell(i_fifo_full) |-> $past(i_pop))
    else $error("Transmit FIFO left full without a pop");

endmodule

bind nemu_serial_port_out nemu_serial_port_asserts u_asserts (
  .i_clk        (i_clk),
  .reset_n      (reset_n),
  .i_running    (l_running),
  .i_pop        (l_pop),
  .i_fifo_full  (l_fifo_full),
  .i_fifo_empty (l_fifo_empty),
  .i_serial_tx  (o_serial_tx)
);

`default_nettype wire

/* test/tb_nemu_serial_port.sv */
// Directed testbench for the NEMU serial port with a switchable loopback line.
`timescale 1ns/1ps
`default_nettype none

module tb_nemu_serial_port
  import serial_cfg_pkg::*, serial_types_pkg::*;
();

  localparam int CLKS_PER_BIT = 8;
  localparam int FIFO_DEPTH   = 4;
  localparam int WAIT_LIMIT   = 20 * FRAME_SLOTS * CLKS_PER_BIT;  // In clock cycles.

  logic         i_clk;
  logic         reset_n;
  logic         tx_wr;
  serial_byte_t tx_data;
  tx_status_t   tx_status;
  logic         serial_tx;
  logic         serial_rx;
  logic         rx_rd;
  rx_word_t     rx_word;
  rx_status_t   rx_status;
  logic         raw_mode;  // The testbench drives the line instead of the transmitter.
  logic         raw_line;
  integer       seed;
  int           check_count;
  int           error_count;
  int           test_errors;

  assign serial_rx = raw_mode ? raw_line : serial_tx;

  nemu_serial_port #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) i_dut (
    .i_clk       (i_clk),
    .reset_n     (reset_n),
    .i_tx_wr     (tx_wr),
    .i_tx_data   (tx_data),
    .o_tx_status (tx_status),
    .o_serial_tx (serial_tx),
    .i_serial_rx (serial_rx),
    .i_rx_rd     (rx_rd),
    .o_rx_word   (rx_word),
    .o_rx_status (rx_status)
  );

  always #5 i_clk = ~i_clk;

  // ##########################################################################
  // Compare tasks and bookkeeping
  // ##########################################################################

  task automatic compare_bit(input logic expected, input logic actual, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: %s expected %b got %b", $time, what, expected, actual);
    end
  endtask

  task automatic compare_word(input rx_word_t expected, input rx_word_t actual,
                              input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: %s expected data %h err %b got data %h err %b", $time,
               what, expected.data, expected.frame_err, actual.data, actual.frame_err);
    end
  endtask

  task automatic compare_tx_status(input tx_status_t expected, input tx_status_t actual,
                                   input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: %s expected full %b empty %b got full %b empty %b",
               $time, what, expected.full, expected.empty, actual.full, actual.empty);
    end
  endtask

  task automatic start_test();
    test_errors = error_count;
  endtask

  task automatic report_test(input string name);
    if (error_count == test_errors) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: %0d errors", name, error_count - test_errors);
    end
  endtask

  task automatic timeout_exit(input string what);
    $display("Timeout: the testbench gave up waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  // ##########################################################################
  // Stimulus tasks
  // ##########################################################################

  // Leaves the strobe high so that calls on consecutive cycles form a burst.
  task automatic write_byte(input serial_byte_t data, output logic accepted);
    @(negedge i_clk);
    accepted = !tx_status.full;  // Full cannot change before the next rising edge.
    tx_wr    = 1'b1;
    tx_data  = data;
  endtask

  task automatic end_write();
    @(negedge i_clk);
    tx_wr = 1'b0;
  endtask

  task automatic pop_word(output rx_word_t word);
    int waited;
    waited = 0;
    @(negedge i_clk);
    while (rx_status.empty) begin
      if (waited == WAIT_LIMIT) begin
        timeout_exit("a received word");
      end
      waited++;
      @(negedge i_clk);
    end
    rx_rd = 1'b1;
    @(negedge i_clk);
    rx_rd = 1'b0;
    word  = rx_word;  // Updated at the edge that took the strobe.
  endtask

  task automatic send_raw_frame(input serial_byte_t data, input logic stop_bit);
    logic [FRAME_SLOTS-1:0] slots;
    slots = {1'b0, data, stop_bit};  // Sent from the top bit down.
    @(negedge i_clk);
    raw_mode = 1'b1;
    for (int s = FRAME_SLOTS - 1; s >= 0; s--) begin
      raw_line = slots[s];
      repeat (CLKS_PER_BIT) @(negedge i_clk);
    end
    raw_line = 1'b1;
    repeat (2 * CLKS_PER_BIT) @(negedge i_clk);
    raw_mode = 1'b0;
  endtask

  // ##########################################################################
  // Tests
  // ##########################################################################

  task automatic test_reset_state();
    start_test();
    @(negedge i_clk);
    compare_bit(1'b1, serial_tx, "line after reset");
    compare_tx_status(tx_status_t'{full: 1'b0, empty: 1'b1}, tx_status, "tx status");
    compare_bit(1'b0, rx_status.full, "rx full after reset");
    compare_bit(1'b1, rx_status.empty, "rx empty after reset");
    compare_word(rx_word_t'{data: 8'h00, frame_err: 1'b0}, rx_word, "rx word after reset");
    report_test("reset state");
  endtask

  task automatic test_frame_format();
    serial_byte_t           data;
    logic                   accepted;
    logic [FRAME_SLOTS-1:0] expected;
    rx_word_t               got;
    int                     waited;
    start_test();
    data     = serial_byte_t'($random(seed));
    expected = {1'b0, data, 1'b1};  // Start, data MSB first, stop.
    write_byte(data, accepted);
    end_write();
    waited = 0;
    while (serial_tx) begin
      if (waited == WAIT_LIMIT) begin
        timeout_exit("the start bit");
      end
      waited++;
      @(negedge i_clk);
    end
    repeat (CLKS_PER_BIT / 2 - 1) @(negedge i_clk);  // Middle of the start bit.
    for (int s = FRAME_SLOTS - 1; s >= 0; s--) begin
      compare_bit(expected[s], serial_tx, $sformatf("line slot %0d", FRAME_SLOTS - 1 - s));
      repeat (CLKS_PER_BIT) @(negedge i_clk);
    end
    pop_word(got);  // The looped back frame is drained as well.
    compare_word(rx_word_t'{data: data, frame_err: 1'b0}, got, "looped frame");
    report_test("frame format");
  endtask

  task automatic test_loopback_order();
    serial_byte_t data;
    serial_byte_t sent[$];
    logic         accepted;
    rx_word_t     got;
    start_test();
    repeat (3) begin
      data = serial_byte_t'($random(seed));
      write_byte(data, accepted);
      sent.push_back(data);
    end
    end_write();
    for (int i = 0; i < sent.size(); i++) begin
      pop_word(got);
      compare_word(rx_word_t'{data: sent[i], frame_err: 1'b0}, got,
                   $sformatf("loopback word %0d", i));
    end
    report_test("loopback ordering");
  endtask

  task automatic test_back_pressure();
    serial_byte_t data;
    serial_byte_t kept[$];
    logic         accepted;
    logic         saw_full;
    rx_word_t     got;
    start_test();
    saw_full = 1'b0;
    for (int i = 0; i < 8; i++) begin
      data = serial_byte_t'($random(seed));
      write_byte(data, accepted);
      if (accepted) begin
        kept.push_back(data);
      end else begin
        saw_full = 1'b1;
      end
    end
    end_write();
    compare_bit(1'b1, saw_full, "full seen during burst");
    // Only one byte leaves the FIFO per frame, so the burst leaves it full.
    compare_tx_status(tx_status_t'{full: 1'b1, empty: 1'b0}, tx_status, "tx after burst");
    for (int i = 0; i < kept.size(); i++) begin
      pop_word(got);
      compare_word(rx_word_t'{data: kept[i], frame_err: 1'b0}, got,
                   $sformatf("accepted word %0d", i));
    end
    compare_bit(1'b1, rx_status.empty, "rx empty after drain");
    report_test("back-pressure");
  endtask

  task automatic test_framing_error();
    serial_byte_t data;
    rx_word_t     got;
    start_test();
    data = serial_byte_t'($random(seed));
    send_raw_frame(data, 1'b0);
    pop_word(got);
    compare_word(rx_word_t'{data: data, frame_err: 1'b1}, got, "frame with low stop");
    data = serial_byte_t'($random(seed));
    send_raw_frame(data, 1'b1);
    pop_word(got);
    compare_word(rx_word_t'{data: data, frame_err: 1'b0}, got, "clean frame after error");
    report_test("framing error");
  endtask

  initial begin
    i_clk       = 1'b0;
    reset_n     = 1'b1;
    tx_wr       = 1'b0;
    tx_data     = '0;
    rx_rd       = 1'b0;
    raw_mode    = 1'b0;
    raw_line    = 1'b1;
    seed        = 32'hd4d7c571;
    check_count = 0;
    error_count = 0;
    test_errors = 0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    reset_n = 1'b0;
    test_reset_state();
    test_frame_format();
    test_loopback_order();
    test_back_pressure();
    test_framing_error();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/serial_cfg_pkg.sv
hw/serial_types_pkg.sv
hw/lib_fifo.sv
hw/nemu_serial_port_out.sv
hw/nemu_serial_port_in.sv
hw/nemu_serial_port.sv
test/nemu_serial_port_asserts.sv
test/tb_nemu_serial_port.sv

/* run_sim.sh */
#!/bin/sh
# Compile the serial port testbench with Verilator and run it.
verilator --binary --timing --assert -j 0 -f verilog.f --top-module tb_nemu_serial_port \
  && ./obj_dir/Vtb_nemu_serial_port | tee /dev/stderr \
     | grep -q "^Simulation completed successfully$" \
  && echo "Run result: pass" \
  || { echo "Run result: fail"; exit 1; }
